// ==== source/knight_params.svh ====
////////////////////
// Step sizes, nudge offsets and limits for the knight command processor.
// Include wherever a block needs one of these values.
////////////////////
`ifndef KNIGHT_PARAMS_SVH
`define KNIGHT_PARAMS_SVH

// Nonzero selects the large simulation step sizes.
`define KN_FAST_SIM 1

// Speed step per gyro reading.
`define KN_INC_AMT ((`KN_FAST_SIM != 0) ? 10'd32 : 10'd3)
`define KN_DEC_AMT ((`KN_FAST_SIM != 0) ? 10'd64 : 10'd6)

// Error offsets when an outer IR sensor sees the line.
`define KN_NUDGE_LFT  ((`KN_FAST_SIM != 0) ? 12'h1FF : 12'h05F)
`define KN_NUDGE_RGHT ((`KN_FAST_SIM != 0) ? 12'hE00 : 12'hFA1)

// Error magnitude that counts as aligned.
`define KN_ALIGN_THRESH 12'h02C

// Default number of queued commands.
`define KN_QUEUE_DEPTH 2

`endif

// ==== source/cmd_pkg.sv ====
////////////////////
// Types for Bluetooth command words and the decoded entries
// passed from the intake through the queue.
////////////////////
package cmd_pkg;

  typedef logic [15:0] cmd_word_t;         // Raw word from the receiver.

  typedef enum logic [3:0] {
    CAL     = 4'h2,                        // Gyro calibration.
    MOV     = 4'h4,                        // Plain move.
    FANFARE = 4'h5,                        // Move with fanfare at the end.
    TOUR    = 4'h6                         // Hand off to the tour block.
  } opcode_t;

  typedef logic [3:0] square_cnt_t;        // Squares to travel.

  typedef logic signed [11:0] heading_t;   // Heading or heading error.

endpackage

// ==== source/motion_pkg.sv ====
////////////////////
// Types for the motion side: controller states, forward speed
// and the centre-line pulse count.
////////////////////
package motion_pkg;

  typedef enum logic [2:0] {
    IDLE,                                  // Waiting for a queued command.
    CALIBRATE,                             // Gyro calibration running.
    ALIGN,                                 // Turning to the new heading.
    ACCEL,                                 // Ramping up and counting lines.
    DECEL                                  // Ramping down to a stop.
  } motion_state_t;

  typedef logic [9:0] speed_t;             // Forward speed to the PID.

  typedef logic [4:0] pulse_cnt_t;         // Centre IR rising edges, two per square.

endpackage

// ==== source/cmd_intake.sv ====
////////////////////
// Takes one word from the Bluetooth receiver, decodes it
// and offers the entry to the queue by valid/ready.
////////////////////
module cmd_intake import cmd_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  cmd_word_t   cmd,            // Word from the receiver.
  input  logic        cmd_rdy,        // Receiver holds a word.
  input  logic        ent_ready,      // Queue can take the entry.
  output logic        clr_cmd_rdy,    // Word consumed this cycle.
  output logic        ent_valid,
  output opcode_t     ent_op,
  output square_cnt_t ent_squares,
  output heading_t    ent_heading
);

  cmd_word_t slot;                    // Held command word.
  logic      full;                    // Slot occupied.
  logic      capture;

  assign capture     = cmd_rdy & ~full;  // Only an empty slot takes a word.
  assign clr_cmd_rdy = capture;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      full <= 1'b0;
    else if (capture)
      full <= 1'b1;
    else if (ent_valid && ent_ready)
      full <= 1'b0;                   // Entry moved into the queue.
  end

  always_ff @(posedge clk) begin
    if (capture)
      slot <= cmd;
  end

  assign ent_valid   = full;
  assign ent_op      = opcode_t'(slot[15:12]);
  assign ent_squares = slot[3:0];
  // Nonzero heading fields get 0xF appended, zero stays zero.
  assign ent_heading = (slot[11:4] == 8'h00) ? heading_t'(0) : heading_t'({slot[11:4], 4'hF});

  // Receiver lets go of its ready the cycle after the clear.
  a_rdy_dropped: assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |=> !cmd_rdy);

endmodule

// ==== source/cmd_queue.sv ====
////////////////////
// Circular FIFO of decoded commands, so a new command can be
// accepted while the robot is still busy with the previous one.
////////////////////
`include "knight_params.svh"

module cmd_queue import cmd_pkg::*; #(
  parameter int depth = `KN_QUEUE_DEPTH
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ent_valid,
  input  opcode_t     ent_op,
  input  square_cnt_t ent_squares,
  input  heading_t    ent_heading,
  input  logic        q_ready,        // Controller pops.
  output logic        ent_ready,
  output logic        q_valid,
  output opcode_t     q_op,
  output square_cnt_t q_squares,
  output heading_t    q_heading
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  opcode_t     op_mem [depth];
  square_cnt_t sq_mem [depth];
  heading_t    hd_mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             wr;
  logic             rd;

  assign ent_ready = (count != cnt_w'(depth));  // Full queue stalls the intake.
  assign q_valid   = (count != '0);
  assign wr        = ent_valid & ent_ready;
  assign rd        = q_valid & q_ready;

  assign q_op      = op_mem[rd_ptr];
  assign q_squares = sq_mem[rd_ptr];
  assign q_heading = hd_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr) begin
      op_mem[wr_ptr] <= ent_op;
      sq_mem[wr_ptr] <= ent_squares;
      hd_mem[wr_ptr] <= ent_heading;
    end
  end

  ////////////////////
  // Pointers and fill count.
  ////////////////////
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at depth.
      if (rd)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (wr && !rd)
        count <= count + 1'b1;
      else if (rd && !wr)
        count <= count - 1'b1;
    end
  end

  // Intake holds its entry steady until the queue takes it.
  a_ent_held: assert property (@(posedge clk) disable iff (!rst_n)
    ent_valid && !ent_ready |=> ent_valid && $stable(ent_op) &&
    $stable(ent_squares) && $stable(ent_heading));

endmodule

// ==== source/speed_ramp.sv ====
////////////////////
// Forward speed register. Ramps on each gyro reading while the
// controller asks for it; cleared before each move.
////////////////////
`include "knight_params.svh"

module speed_ramp import motion_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   clr,                 // Start a move from standstill.
  input  logic   inc,                 // Ramp up.
  input  logic   dec,                 // Ramp down.
  input  logic   heading_rdy,         // New gyro reading, paces the ramp.
  output speed_t frwrd,
  output logic   zero                 // Speed is zero.
);

  logic max_spd;

  assign zero    = (frwrd == '0);
  assign max_spd = &frwrd[9:8];       // Both top bits set.

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      frwrd <= '0;
    else if (clr)
      frwrd <= '0;
    else if (heading_rdy) begin
      if (inc && !max_spd)
        frwrd <= frwrd + `KN_INC_AMT;
      else if (dec && !zero)
        // Last step lands on zero instead of wrapping.
        frwrd <= (frwrd > `KN_DEC_AMT) ? frwrd - `KN_DEC_AMT : '0;
    end
  end

  a_inc_dec_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(inc && dec));

endmodule

// ==== source/heading_error.sv ====
////////////////////
// Holds the desired heading of the current move and forms the
// error for the PID, nudged by the outer IR sensors.
////////////////////
`include "knight_params.svh"

module heading_error import cmd_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,              // New move popped.
  input  heading_t desired,           // Heading from the queue head.
  input  heading_t heading,           // Gyro heading.
  input  logic     lft_ir,            // Drifted onto the left line.
  input  logic     rght_ir,           // Drifted onto the right line.
  output heading_t error,
  output logic     aligned            // Close enough to start moving.
);

  heading_t   desired_r;
  heading_t   nudge;
  logic [11:0] err_abs;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      desired_r <= '0;
    else if (load)
      desired_r <= desired;
  end

  // Left wins when both see a line.
  assign nudge = lft_ir  ? heading_t'(`KN_NUDGE_LFT) :
                 rght_ir ? heading_t'(`KN_NUDGE_RGHT) :
                           heading_t'(0);

  assign error   = heading - desired_r + nudge;
  assign err_abs = error[11] ? -error : error;
  assign aligned = (err_abs < `KN_ALIGN_THRESH);

endmodule

// ==== source/motion_ctrl.sv ====
////////////////////
// Command FSM. Pops one queued command per completed command,
// counts centre-line crossings and drives all pulse outputs.
////////////////////
module motion_ctrl import cmd_pkg::*, motion_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        q_valid,
  input  opcode_t     q_op,
  input  square_cnt_t q_squares,
  input  logic        cal_done,       // Gyro calibration finished.
  input  logic        cntr_ir,        // Centre IR over a line.
  input  logic        aligned,        // Heading error small.
  input  logic        zero,           // Speed at zero.
  output logic        q_ready,        // Pop the queue head.
  output logic        load_heading,
  output logic        strt_cal,
  output logic        send_resp,
  output logic        tour_go,
  output logic        fanfare_go,
  output logic        moving,         // Lets the gyro integrate yaw.
  output logic        clr_speed,
  output logic        inc_speed,
  output logic        dec_speed
);

  motion_state_t state;
  motion_state_t nxt_state;
  opcode_t       op_r;                // Opcode of the running command.
  square_cnt_t   squares_r;
  pulse_cnt_t    pulse_cnt;
  logic          cntr_prev;
  logic          pulse;
  logic          move_done;
  logic          pop;

  assign q_ready = (state == IDLE);   // One pop per finished command.
  assign pop     = q_valid & q_ready;

  ////////////////////
  // Centre-line counting.
  ////////////////////
  assign pulse     = cntr_ir & ~cntr_prev;                 // Rising edge.
  assign move_done = (pulse_cnt == {squares_r, 1'b0});     // Two lines per square.

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cntr_prev <= 1'b0;
      pulse_cnt <= '0;
    end else begin
      cntr_prev <= cntr_ir;
      if (load_heading)
        pulse_cnt <= '0;
      else if (pulse)
        pulse_cnt <= pulse_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      op_r      <= q_op;
      squares_r <= q_squares;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      state <= IDLE;
    else
      state <= nxt_state;
  end

  always_comb begin
    nxt_state    = state;
    load_heading = 1'b0;
    strt_cal     = 1'b0;
    send_resp    = 1'b0;
    tour_go      = 1'b0;
    fanfare_go   = 1'b0;
    moving       = 1'b0;
    clr_speed    = 1'b0;
    inc_speed    = 1'b0;
    dec_speed    = 1'b0;

    case (state)
      CALIBRATE: begin
        if (cal_done) begin
          send_resp = 1'b1;
          nxt_state = IDLE;
        end
      end

      ALIGN: begin
        moving = 1'b1;                // Turning in place counts as moving.
        if (aligned) begin
          clr_speed = 1'b1;
          nxt_state = ACCEL;
        end
      end

      ACCEL: begin
        moving    = 1'b1;
        inc_speed = 1'b1;
        if (move_done) begin
          fanfare_go = (op_r == FANFARE);
          nxt_state  = DECEL;
        end
      end

      DECEL: begin
        dec_speed = 1'b1;
        if (zero) begin
          send_resp = 1'b1;
          nxt_state = IDLE;
        end else
          moving = 1'b1;
      end

      default: begin                  // IDLE.
        if (pop) begin
          case (q_op)
            TOUR:    tour_go = 1'b1;  // No response, the tour block answers.
            CAL: begin
              strt_cal  = 1'b1;
              nxt_state = CALIBRATE;
            end
            MOV, FANFARE: begin
              load_heading = 1'b1;
              nxt_state    = ALIGN;
            end
            default: ;                // Unknown opcode is dropped.
          endcase
        end
      end
    endcase
  end

  // Ramp up always starts from standstill.
  a_accel_from_rest: assert property (@(posedge clk) disable iff (!rst_n)
    state == ALIGN && aligned |=> zero);

endmodule

// ==== source/cmd_proc.sv ====
////////////////////
// Knight command processor top. Intake, queue and motion FSM,
// with the speed ramp and heading error feeding the PID.
////////////////////
`include "knight_params.svh"

module cmd_proc import cmd_pkg::*, motion_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  cmd_word_t cmd,              // Bluetooth command word.
  input  logic      cmd_rdy,
  input  logic      cal_done,
  input  heading_t  heading,          // Gyro heading.
  input  logic      heading_rdy,
  input  logic      lft_ir,
  input  logic      cntr_ir,
  input  logic      rght_ir,
  output logic      clr_cmd_rdy,
  output logic      send_resp,
  output logic      strt_cal,
  output logic      moving,
  output heading_t  error,            // To the PID.
  output speed_t    frwrd,            // To the PID.
  output logic      tour_go,
  output logic      fanfare_go
);

  logic        ent_valid;
  logic        ent_ready;
  opcode_t     ent_op;
  square_cnt_t ent_squares;
  heading_t    ent_heading;
  logic        q_valid;
  logic        q_ready;
  opcode_t     q_op;
  square_cnt_t q_squares;
  heading_t    q_heading;
  logic        load_heading;
  logic        aligned;
  logic        zero;
  logic        clr_speed;
  logic        inc_speed;
  logic        dec_speed;

  cmd_intake u_intake (
    .clk(clk), .rst_n(rst_n), .cmd(cmd), .cmd_rdy(cmd_rdy), .ent_ready(ent_ready),
    .clr_cmd_rdy(clr_cmd_rdy), .ent_valid(ent_valid), .ent_op(ent_op),
    .ent_squares(ent_squares), .ent_heading(ent_heading)
  );

  cmd_queue #(.depth(`KN_QUEUE_DEPTH)) u_queue (
    .clk(clk), .rst_n(rst_n), .ent_valid(ent_valid), .ent_op(ent_op),
    .ent_squares(ent_squares), .ent_heading(ent_heading), .q_ready(q_ready),
    .ent_ready(ent_ready), .q_valid(q_valid), .q_op(q_op), .q_squares(q_squares),
    .q_heading(q_heading)
  );

  motion_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n), .q_valid(q_valid), .q_op(q_op), .q_squares(q_squares),
    .cal_done(cal_done), .cntr_ir(cntr_ir), .aligned(aligned), .zero(zero),
    .q_ready(q_ready), .load_heading(load_heading), .strt_cal(strt_cal),
    .send_resp(send_resp), .tour_go(tour_go), .fanfare_go(fanfare_go),
    .moving(moving), .clr_speed(clr_speed), .inc_speed(inc_speed), .dec_speed(dec_speed)
  );

  speed_ramp u_ramp (
    .clk(clk), .rst_n(rst_n), .clr(clr_speed), .inc(inc_speed), .dec(dec_speed),
    .heading_rdy(heading_rdy), .frwrd(frwrd), .zero(zero)
  );

  heading_error u_herr (
    .clk(clk), .rst_n(rst_n), .load(load_heading), .desired(q_heading),
    .heading(heading), .lft_ir(lft_ir), .rght_ir(rght_ir), .error(error),
    .aligned(aligned)
  );

endmodule

// ==== tb/tb_cmd_proc.sv ====
////////////////////
// Testbench for the knight command processor. Sends a table of
// Bluetooth commands and models the gyro, IR sensors and calibration.
// Responses are checked in table order as they come out.
////////////////////
`include "knight_params.svh"

module tb_cmd_proc import cmd_pkg::*, motion_pkg::*; ();

  localparam int n_rows      = 10;
  localparam int first_burst = 5;               // Rows from here on go back to back.
  localparam int cycle_limit = n_rows * 400 + 20;
  localparam int k_cal  = 0;                    // Kinds of response.
  localparam int k_move = 1;
  localparam int k_fan  = 2;
  localparam int k_tour = 3;

  logic      clk = 1'b0;
  logic      rst_n;
  cmd_word_t cmd;
  logic      cmd_rdy;
  logic      cal_done = 1'b0;
  heading_t  heading = '0;
  logic      heading_rdy = 1'b0;
  logic      lft_ir = 1'b0;
  logic      cntr_ir = 1'b0;
  logic      rght_ir = 1'b0;
  logic      clr_cmd_rdy;
  logic      send_resp;
  logic      strt_cal;
  logic      moving;
  heading_t  error;
  speed_t    frwrd;
  logic      tour_go;
  logic      fanfare_go;

  opcode_t     tbl_op   [n_rows];
  logic [7:0]  tbl_hd   [n_rows];               // Heading field of the command.
  square_cnt_t tbl_sq   [n_rows];
  logic [1:0]  tbl_ir   [n_rows];               // {lft, rght} while under way.
  int          tbl_kind [n_rows];

  int     exp_idx = 0;                          // Row whose response comes next.
  int     cycles = 0;
  int     edges = 0;                            // cntr_ir rising edges driven.
  int     row_edges = 0;                        // Edge count when the row started.
  int     hr_gap = 1;
  int     cl_gap = 3;
  int     cal_wait = 0;
  int     cal_starts = 0;
  int     cal_resps = 0;
  int     cal_served = 0;
  logic   strt_seen = 1'b0;
  logic   fan_seen = 1'b0;
  logic   cal_prev = 1'b0;
  logic   hr_prev = 1'b0;                       // heading_rdy of the last cycle.
  speed_t frwrd_prev = '0;

  cmd_proc u_dut (.*);

  always #50 clk = ~clk;

  task automatic abort(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_heading(input string name, input heading_t exp, input heading_t act);
    if (exp !== act)
      abort($sformatf("FAILED %s: expected %h, got %h", name, exp, act));
  endtask

  task automatic check_speed(input string name, input speed_t exp, input speed_t act);
    if (exp !== act)
      abort($sformatf("FAILED %s: expected %h, got %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
      abort($sformatf("FAILED %s: expected %h, got %h", name, exp, act));
  endtask

  // Field 0 means heading zero, anything else gets 0xF appended.
  function automatic heading_t desired_of(input logic [7:0] field);
    return (field == 8'h00) ? heading_t'(0) : heading_t'({field, 4'hF});
  endfunction

  function automatic int cur_row();
    return (exp_idx < n_rows) ? exp_idx : n_rows - 1;
  endfunction

  task automatic set_row(input int i, input opcode_t op, input logic [7:0] hd,
                         input square_cnt_t sq, input logic [1:0] ir, input int kind);
    tbl_op[i]   = op;
    tbl_hd[i]   = hd;
    tbl_sq[i]   = sq;
    tbl_ir[i]   = ir;
    tbl_kind[i] = kind;
  endtask

  task automatic load_table();
    set_row(0, CAL,     8'h00, 4'd0, 2'b00, k_cal);
    set_row(1, MOV,     8'h40, 4'd2, 2'b00, k_move);
    set_row(2, MOV,     8'hA5, 4'd3, 2'b10, k_move);   // Left nudge.
    set_row(3, FANFARE, 8'h00, 4'd2, 2'b01, k_fan);    // Right nudge.
    set_row(4, TOUR,    8'h12, 4'd0, 2'b00, k_tour);
    set_row(5, MOV,     8'hC3, 4'd8, 2'b11, k_move);   // Long move, both lines seen.
    set_row(6, TOUR,    8'h07, 4'd0, 2'b00, k_tour);
    set_row(7, CAL,     8'h00, 4'd0, 2'b00, k_cal);
    set_row(8, FANFARE, 8'h3C, 4'd1, 2'b10, k_fan);
    set_row(9, MOV,     8'hF0, 4'd2, 2'b01, k_move);   // Waits behind a full queue.
  endtask

  // Holds cmd_rdy until the DUT clears it, as the receiver does.
  task automatic send_cmd(input cmd_word_t word, input logic expect_stall);
    @(posedge clk);
    #5;
    cmd     = word;
    cmd_rdy = 1'b1;
    @(negedge clk);
    if (expect_stall)
      check_bit("clr_cmd_rdy", 1'b0, clr_cmd_rdy);
    while (!clr_cmd_rdy)
      @(negedge clk);
    @(posedge clk);
    #5;
    cmd_rdy = 1'b0;
  endtask

  task automatic wait_done(input int target);
    while (exp_idx < target)
      @(negedge clk);
  endtask

  task automatic check_idle();
    check_bit("send_resp", 1'b0, send_resp);
    check_bit("strt_cal", 1'b0, strt_cal);
    check_bit("tour_go", 1'b0, tour_go);
    check_bit("fanfare_go", 1'b0, fanfare_go);
    check_bit("moving", 1'b0, moving);
    check_bit("clr_cmd_rdy", 1'b0, clr_cmd_rdy);
    check_speed("frwrd", '0, frwrd);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit)
      abort($sformatf("Timeout after %0d cycles with %0d responses seen", cycles, exp_idx));
  end

  ////////////////////
  // Gyro, IR and calibration models.
  ////////////////////
  always @(posedge clk) begin
    #5;
    if (rst_n) begin
      heading_rdy = (hr_gap == 1);              // A reading every 1 to 4 cycles.
      hr_gap = (hr_gap == 1) ? int'($urandom % 4) + 1 : hr_gap - 1;
      if (frwrd != '0) begin                    // Under way, small wobble and drift.
        heading = desired_of(tbl_hd[cur_row()]) + heading_t'(cycles[2:0]) - heading_t'(4);
        lft_ir  = tbl_ir[cur_row()][1];
        rght_ir = tbl_ir[cur_row()][0];
      end else begin
        heading = desired_of(tbl_hd[cur_row()]); // Turn is done at once.
        lft_ir  = 1'b0;
        rght_ir = 1'b0;
      end
      if (cntr_ir)
        cntr_ir = 1'b0;                         // One-cycle line pulses.
      else if (moving && cl_gap == 0) begin
        cntr_ir = 1'b1;
        edges++;
        cl_gap = int'($urandom % 6) + 2;
      end else if (moving)
        cl_gap--;
      if (cal_done) begin
        if (cal_resps > cal_served) begin       // Response seen, drop it.
          cal_done = 1'b0;
          cal_served++;
        end
      end else if (cal_starts > cal_served) begin
        cal_wait++;
        if (cal_wait == 12) begin
          cal_done = 1'b1;
          cal_wait = 0;
        end
      end
    end
  end

  ////////////////////
  // Response and speed monitor.
  ////////////////////
  always @(negedge clk) begin
    if (rst_n) begin
      if ((send_resp || strt_cal || tour_go || fanfare_go) && exp_idx >= n_rows)
        abort("A response came after the last command finished");
      if (moving)
        check_heading("error", heading - desired_of(tbl_hd[cur_row()]) +
                      (lft_ir ? heading_t'(`KN_NUDGE_LFT) :
                       rght_ir ? heading_t'(`KN_NUDGE_RGHT) : heading_t'(0)), error);
      if (!hr_prev)
        check_speed("frwrd", frwrd_prev, frwrd);   // No reading, no change.
      else if (frwrd > frwrd_prev)
        check_speed("frwrd", frwrd_prev + `KN_INC_AMT, frwrd);
      else if (frwrd < frwrd_prev)
        check_speed("frwrd", (frwrd_prev > `KN_DEC_AMT) ? frwrd_prev - `KN_DEC_AMT : '0, frwrd);
      if (frwrd > 10'h300 + `KN_INC_AMT)
        abort($sformatf("FAILED frwrd: expected at most %h, got %h",
                        10'h300 + `KN_INC_AMT, frwrd));
      hr_prev    = heading_rdy;
      frwrd_prev = frwrd;

      if (strt_cal) begin
        check_bit("strt_cal", tbl_kind[cur_row()] == k_cal && !strt_seen, strt_cal);
        strt_seen = 1'b1;
        cal_starts++;
      end
      if (fanfare_go) begin
        check_bit("fanfare_go", tbl_kind[cur_row()] == k_fan && !fan_seen, fanfare_go);
        fan_seen = 1'b1;
      end
      if (tour_go || send_resp) begin
        check_bit("tour_go", tbl_kind[cur_row()] == k_tour, tour_go);
        check_bit("send_resp", tbl_kind[cur_row()] != k_tour, send_resp);
        if (tbl_kind[cur_row()] == k_cal) begin
          check_bit("strt_cal seen", 1'b1, strt_seen);
          check_bit("cal_done", 1'b1, cal_done);
          check_bit("cal_done last cycle", 1'b0, cal_prev);  // First cycle only.
          cal_resps++;
        end else if (tbl_kind[cur_row()] != k_tour) begin
          if (edges - row_edges < 2 * int'(tbl_sq[cur_row()]))
            abort($sformatf("Move answered after %0d centre-line edges, %0d needed",
                            edges - row_edges, 2 * int'(tbl_sq[cur_row()])));
          check_speed("frwrd", '0, frwrd);
          check_bit("fanfare_go seen", tbl_kind[cur_row()] == k_fan, fan_seen);
        end
        exp_idx++;                              // Next row in table order.
        row_edges = edges;
        strt_seen = 1'b0;
        fan_seen  = 1'b0;
      end
      cal_prev = cal_done;
    end
  end

  initial begin
    void'($urandom(32'h1837_b7d3));
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_rdy = 1'b0;
    load_table();
    repeat (10) @(posedge clk);
    #5 rst_n = 1'b1;
    @(negedge clk);
    check_idle();
    for (int i = 0; i < n_rows; i++) begin
      send_cmd({tbl_op[i], tbl_hd[i], tbl_sq[i]}, i == n_rows - 1);
      if (i < first_burst)
        wait_done(i + 1);                       // One at a time before the burst.
    end
    wait_done(n_rows);
    repeat (4) @(negedge clk);
    check_idle();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+source
source/cmd_pkg.sv
source/motion_pkg.sv
source/cmd_intake.sv
source/cmd_queue.sv
source/speed_ramp.sv
source/heading_error.sv
source/motion_ctrl.sv
source/cmd_proc.sv
tb/tb_cmd_proc.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' filelist.f) $(wildcard source/*.svh)

obj_dir/Vtb_cmd_proc: $(SRCS) filelist.f
	verilator --binary --timing --assert --top-module tb_cmd_proc -f filelist.f

run: obj_dir/Vtb_cmd_proc
	./obj_dir/Vtb_cmd_proc | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean
